// File: tb.f
gb_pkg.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_internal_ram.sv
gb_cart_bus.sv
gb_sys_regs.sv
gb_core.sv
tb_gb_core.sv

// File: Makefile
SRCS := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/Vtb_gb_core
	./obj_dir/Vtb_gb_core

obj_dir/Vtb_gb_core: $(SRCS) tb.f
	verilator --binary --assert --top-module tb_gb_core -f tb.f

clean:
	rm -rf obj_dir

// File: tb_gb_core.sv
// testbench for the system glue top with cpu bus tasks, lfsr data, assertions and watchdog
`timescale 1ns/10ps

module tb_gb_core;

	localparam int WATCHDOG_CYCLES = 2000;   // tests need about 300 cycles

	logic        clk_sys = 1'b0;
	logic        reset_ss = 1'b1;
	logic        is_gbc_i = 1'b1;           // cgb mode for the whole run
	logic [15:0] cpu_addr_i = '0;
	logic [7:0]  cpu_do_i = '0;
	logic        cpu_rd_n_i = 1'b1;
	logic        cpu_wr_n_i = 1'b1;
	logic        cpu_m1_n_i = 1'b1;
	logic        cpu_iorq_n_i = 1'b1;
	logic        cpu_stop_i = 1'b0;
	logic        vblank_irq_i = 1'b0;
	logic        lcd_irq_i = 1'b0;
	logic        timer_irq_i = 1'b0;
	logic        serial_irq_i = 1'b0;
	logic [3:0]  joy_din_i = 4'hf;          // no button pressed
	logic [7:0]  cart_do_i = '0;
	logic        cart_oe_i = 1'b0;
	logic [7:0]  cpu_di_o;
	logic        irq_n_o;
	logic [1:0]  joy_p54_o;
	logic [14:0] ext_addr_o;
	logic        ext_a15_o;
	logic        cart_rd_o;
	logic        cart_wr_o;
	logic        n_cs_o;
	logic [7:0]  cart_di_o;
	logic        speed_o;

	logic [31:0] lfsr_q = 32'h212b_9d6d;
	logic        rd_seen;                   // cart pins at the read sample point
	logic        ncs_seen;
	logic [14:0] addr_seen;
	logic        a15_seen;
	int          wr_pulses;                 // cart_wr_o cycles inside one write
	logic        wr_ncs;
	logic        wr_a15;
	logic [7:0]  wr_data;

	gb_core uut (.*);

	always #10 clk_sys = ~clk_sys;

	// --------------------
	// helpers
	// --------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
		assert (got === exp) else
			stop_run($sformatf("Fail %0t: %s is %02h, expected %02h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		assert (got === exp) else
			stop_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			lfsr_q = lfsr_next(lfsr_q);   // one step per bit
			b = {b[6:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [4:0] lowest_bit(input logic [4:0] m);
		return m & (~m + 5'd1);
	endfunction

	function automatic logic [7:0] expected_vector(input logic [4:0] m);
		logic [7:0] vec;
		vec = 8'h00;
		for (int i = 0; i < 5; i++) begin
			if (m[i] && vec == 8'h00)
				vec = 8'h40 + 8'(8 * i);   // first hit is the highest priority
		end
		return vec;
	endfunction

	// --------------------
	// cpu bus
	// --------------------
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		wr_pulses = 0;
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_do_i   <= data;
		cpu_wr_n_i <= 1'b0;
		repeat (3) begin
			@(negedge clk_sys);
			if (cart_wr_o) begin
				wr_pulses++;
				wr_ncs  = n_cs_o;
				wr_a15  = ext_a15_o;
				wr_data = cart_di_o;
			end
		end
		@(posedge clk_sys);
		cpu_wr_n_i <= 1'b1;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_rd_n_i <= 1'b0;
		repeat (3) @(negedge clk_sys);   // ram data is out by the last cycle
		data      = cpu_di_o;
		rd_seen   = cart_rd_o;
		ncs_seen  = n_cs_o;
		addr_seen = ext_addr_o;
		a15_seen  = ext_a15_o;
		@(posedge clk_sys);
		cpu_rd_n_i <= 1'b1;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] got;
		bus_read(addr, got);
		check_eq(got, exp, what);
	endtask

	task automatic ack_cycle(output logic [7:0] vec);
		@(posedge clk_sys);
		cpu_m1_n_i   <= 1'b0;
		cpu_iorq_n_i <= 1'b0;
		@(negedge clk_sys);
		vec = cpu_di_o;
		@(posedge clk_sys);
		cpu_m1_n_i   <= 1'b1;
		cpu_iorq_n_i <= 1'b1;
	endtask

	task automatic pulse_source(input int idx);
		@(posedge clk_sys);
		{serial_irq_i, timer_irq_i, lcd_irq_i, vblank_irq_i} <= 4'(1 << idx);
		@(posedge clk_sys);
		{serial_irq_i, timer_irq_i, lcd_irq_i, vblank_irq_i} <= 4'b0000;
	endtask

	// --------------------
	// bus protocol checks
	// --------------------
	assert property (@(posedge clk_sys) disable iff (reset_ss) cart_wr_o |-> !$past(cart_wr_o))
		else stop_run($sformatf("Fail %0t: cart_wr_o high for two cycles", $time));
	assert property (@(posedge clk_sys) disable iff (reset_ss)
		!n_cs_o |-> cpu_addr_i[15:13] == 3'b101)   // cs only for cart ram
		else stop_run($sformatf("Fail %0t: n_cs_o low outside a000-bfff", $time));

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		stop_run("timeout: the tests did not finish within the watchdog limit");
	end

	initial begin
		logic [7:0] rd;
		logic [7:0] v;
		logic [7:0] c0_byte;
		logic [7:0] bank_byte [1:3];
		logic [7:0] hram_byte [3];
		logic [4:0] ie_mask;
		logic [4:0] if_mask;

		repeat (16) @(posedge clk_sys);
		reset_ss <= 1'b0;
		@(negedge clk_sys);
		check_bit(irq_n_o, 1'b1, "irq_n_o after reset");
		check_bit(cart_rd_o, 1'b0, "cart_rd_o after reset");
		check_bit(cart_wr_o, 1'b0, "cart_wr_o after reset");
		check_bit(n_cs_o, 1'b1, "n_cs_o after reset");
		check_bit(speed_o, 1'b0, "speed_o after reset");
		check_eq({6'b0, joy_p54_o}, 8'h00, "joy_p54_o after reset");

		// work ram with one byte per bank
		for (int b = 1; b <= 3; b++) begin
			bus_write(gb_pkg::ADDR_SVBK, 8'(b));
			rand_byte(bank_byte[b]);
			bus_write(16'hd000, bank_byte[b]);
		end
		rand_byte(c0_byte);
		bus_write(16'hc000, c0_byte);
		for (int b = 1; b <= 3; b++) begin
			bus_write(gb_pkg::ADDR_SVBK, 8'(b));
			read_check(16'hd000, bank_byte[b], "d000 in its own bank");
		end
		bus_write(gb_pkg::ADDR_SVBK, 8'h00);
		read_check(16'hd000, bank_byte[1], "d000 with svbk 0");
		read_check(16'hc000, c0_byte, "c000 bank 0");
		read_check(16'he000, c0_byte, "e000 echo of c000");
		rand_byte(v);
		bus_write(gb_pkg::ADDR_SVBK, v);
		read_check(gb_pkg::ADDR_SVBK, {5'h1f, v[2:0]}, "svbk read");

		// zero page then ie
		for (int k = 0; k < 3; k++) begin
			rand_byte(hram_byte[k]);
			bus_write(16'hff80 + 16'(k * 63), hram_byte[k]);   // ff80 ffbf fffe
		end
		for (int k = 0; k < 3; k++)
			read_check(16'hff80 + 16'(k * 63), hram_byte[k], "zero-page ram");
		rand_byte(v);
		bus_write(gb_pkg::ADDR_IE, v);
		read_check(gb_pkg::ADDR_IE, v, "ie read");

		// --------------------
		// interrupts
		// --------------------
		ie_mask = 5'b01010;   // lcd and serial only
		bus_write(gb_pkg::ADDR_IE, {3'b000, ie_mask});
		for (int i = 0; i < 4; i++) begin
			bus_write(gb_pkg::ADDR_IF, 8'h00);
			pulse_source(i);
			@(negedge clk_sys);
			check_bit(irq_n_o, !ie_mask[i], "irq_n_o after source pulse");
			read_check(gb_pkg::ADDR_IF, 8'he0 | 8'(1 << i), "if after source pulse");
		end
		ie_mask = 5'b10110;
		if_mask = 5'b11101;
		bus_write(gb_pkg::ADDR_IE, {3'b000, ie_mask});
		bus_write(gb_pkg::ADDR_IF, {3'b000, if_mask});
		repeat (2) begin
			ack_cycle(rd);
			check_eq(rd, expected_vector(if_mask & ie_mask), "ack vector");
			if_mask = if_mask & ~lowest_bit(if_mask & ie_mask);   // serviced flag drops
			read_check(gb_pkg::ADDR_IF, {3'b111, if_mask}, "if after ack");
		end
		@(negedge clk_sys);
		check_bit(irq_n_o, 1'b1, "irq_n_o with nothing pending");
		bus_write(gb_pkg::ADDR_IF, 8'h00);
		@(posedge clk_sys);
		joy_din_i <= 4'b1011;   // p12 pressed
		repeat (3) @(posedge clk_sys);   // two sync stages and the flag edge
		read_check(gb_pkg::ADDR_IF, 8'hf0, "if after joypad fall");

		// --------------------
		// cartridge
		// --------------------
		rand_byte(v);
		@(posedge clk_sys);
		cart_do_i <= v;
		cart_oe_i <= 1'b1;
		bus_read(16'h3a5c, rd);
		check_eq(rd, v, "rom read with cart_oe_i");
		check_bit(rd_seen, 1'b1, "cart_rd_o in rom read");
		check_bit(ncs_seen, 1'b1, "n_cs_o in rom read");
		check_bit(a15_seen, 1'b0, "ext_a15_o in rom read");
		assert (addr_seen === 15'h3a5c) else
			stop_run($sformatf("Fail %0t: ext_addr_o is %04h", $time, addr_seen));
		@(posedge clk_sys);
		cart_oe_i <= 1'b0;
		read_check(16'h3a5c, v, "open bus before decay");
		repeat (gb_pkg::OPEN_BUS_DECAY) @(posedge clk_sys);
		read_check(16'h3a5c, 8'hff, "open bus after decay");
		rand_byte(v);
		bus_write(16'ha000, v);
		check_eq(8'(wr_pulses), 8'h01, "cart_wr_o pulses per write");
		check_bit(wr_ncs, 1'b0, "n_cs_o in cart ram write");
		check_bit(wr_a15, 1'b1, "ext_a15_o in cart ram write");
		check_eq(wr_data, v, "cart_di_o in cart ram write");

		// key1 and joyp
		bus_write(gb_pkg::ADDR_KEY1, 8'h01);
		read_check(gb_pkg::ADDR_KEY1, 8'h7f, "key1 with prepare");
		@(posedge clk_sys);
		cpu_stop_i <= 1'b1;
		@(posedge clk_sys);
		cpu_stop_i <= 1'b0;
		@(negedge clk_sys);
		check_bit(speed_o, 1'b1, "speed_o after stop");
		read_check(gb_pkg::ADDR_KEY1, 8'hfe, "key1 after switch");
		rand_byte(v);
		bus_write(gb_pkg::ADDR_JOYP, v);
		@(negedge clk_sys);
		check_eq({6'b0, joy_p54_o}, {6'b0, v[5:4]}, "joy_p54_o");
		rand_byte(rd);
		@(posedge clk_sys);
		joy_din_i <= rd[3:0];
		read_check(gb_pkg::ADDR_JOYP, {2'b11, v[5:4], rd[3:0]}, "joyp read");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: gb_core.sv
// system glue top level, block instances and interconnect
`timescale 1ns/10ps

module gb_core (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        is_gbc_i,
	// cpu side
	input  logic [15:0] cpu_addr_i,
	input  logic [7:0]  cpu_do_i,
	input  logic        cpu_rd_n_i,
	input  logic        cpu_wr_n_i,
	input  logic        cpu_m1_n_i,
	input  logic        cpu_iorq_n_i,
	input  logic        cpu_stop_i,
	output logic [7:0]  cpu_di_o,
	output logic        irq_n_o,
	// interrupt sources
	input  logic        vblank_irq_i,
	input  logic        lcd_irq_i,
	input  logic        timer_irq_i,
	input  logic        serial_irq_i,
	// joypad
	input  logic [3:0]  joy_din_i,
	output logic [1:0]  joy_p54_o,
	// cartridge
	output logic [14:0] ext_addr_o,
	output logic        ext_a15_o,
	output logic        cart_rd_o,
	output logic        cart_wr_o,
	output logic        n_cs_o,
	output logic [7:0]  cart_di_o,
	input  logic [7:0]  cart_do_i,
	input  logic        cart_oe_i,
	output logic        speed_o
);

	logic       sel_ie, sel_if, sel_wram, sel_hram;
	logic       sel_svbk, sel_key1, sel_joyp, sel_ext;
	logic       wr_stb, irq_ack;
	logic [7:0] irq_vec, if_do, ie_do, ram_do, svbk_do, sys_do, reg_do, cart_rd_do;

	// both sources idle at ff, so and merges them
	assign reg_do = sys_do & svbk_do;

	gb_bus_decode u_decode (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .cpu_addr_i(cpu_addr_i),
		.cpu_wr_n_i(cpu_wr_n_i), .cpu_rd_n_i(cpu_rd_n_i), .cpu_m1_n_i(cpu_m1_n_i),
		.cpu_iorq_n_i(cpu_iorq_n_i), .irq_vec_i(irq_vec), .if_do_i(if_do),
		.ie_do_i(ie_do), .ram_do_i(ram_do), .sys_do_i(reg_do), .cart_rd_do_i(cart_rd_do),
		.sel_ie_o(sel_ie), .sel_if_o(sel_if), .sel_wram_o(sel_wram), .sel_hram_o(sel_hram),
		.sel_svbk_o(sel_svbk), .sel_key1_o(sel_key1), .sel_joyp_o(sel_joyp),
		.sel_ext_o(sel_ext), .wr_stb_o(wr_stb), .irq_ack_o(irq_ack), .cpu_di_o(cpu_di_o)
	);

	gb_irq_ctrl u_irq (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .sel_ie_i(sel_ie), .sel_if_i(sel_if),
		.wr_stb_i(wr_stb), .irq_ack_i(irq_ack), .cpu_do_i(cpu_do_i),
		.vblank_irq_i(vblank_irq_i), .lcd_irq_i(lcd_irq_i), .timer_irq_i(timer_irq_i),
		.serial_irq_i(serial_irq_i), .joy_din_i(joy_din_i), .irq_n_o(irq_n_o),
		.irq_vec_o(irq_vec), .if_do_o(if_do), .ie_do_o(ie_do)
	);

	gb_internal_ram u_ram (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_gbc_i(is_gbc_i),
		.cpu_addr_i(cpu_addr_i), .cpu_do_i(cpu_do_i), .wr_stb_i(wr_stb),
		.sel_wram_i(sel_wram), .sel_hram_i(sel_hram), .sel_svbk_i(sel_svbk),
		.ram_do_o(ram_do), .svbk_do_o(svbk_do)
	);

	gb_cart_bus u_cart (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .cpu_addr_i(cpu_addr_i),
		.cpu_do_i(cpu_do_i), .cpu_rd_n_i(cpu_rd_n_i), .wr_stb_i(wr_stb),
		.sel_ext_i(sel_ext), .cart_do_i(cart_do_i), .cart_oe_i(cart_oe_i),
		.ext_addr_o(ext_addr_o), .ext_a15_o(ext_a15_o), .n_cs_o(n_cs_o),
		.cart_rd_o(cart_rd_o), .cart_wr_o(cart_wr_o), .cart_di_o(cart_di_o),
		.cart_rd_do_o(cart_rd_do)
	);

	gb_sys_regs u_sys (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_gbc_i(is_gbc_i),
		.cpu_do_i(cpu_do_i), .wr_stb_i(wr_stb), .sel_key1_i(sel_key1),
		.sel_joyp_i(sel_joyp), .cpu_stop_i(cpu_stop_i), .joy_din_i(joy_din_i),
		.speed_o(speed_o), .joy_p54_o(joy_p54_o), .sys_do_o(sys_do)
	);

endmodule

// File: gb_sys_regs.sv
// key1 cgb speed-switch register and joypad line-select register
`timescale 1ns/10ps

module gb_sys_regs (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic                       is_gbc_i,
	input  logic [gb_pkg::DATA_W-1:0]  cpu_do_i,
	input  logic                       wr_stb_i,
	input  logic                       sel_key1_i,
	input  logic                       sel_joyp_i,
	input  logic                       cpu_stop_i,
	input  logic [3:0]                 joy_din_i,
	output logic                       speed_o,
	output logic [1:0]                 joy_p54_o,
	output logic [gb_pkg::DATA_W-1:0]  sys_do_o
);

	logic       speed_r;     // 0 normal, 1 double speed
	logic       prepare_r;   // armed by key1 bit 0
	logic [1:0] p54_r;       // joypad row select

	// --------------------
	// key1
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed_r   <= 1'b0;
			prepare_r <= 1'b0;
		end else if (is_gbc_i && prepare_r && cpu_stop_i) begin
			speed_r   <= ~speed_r;   // stop executes the switch
			prepare_r <= 1'b0;
		end else if (is_gbc_i && sel_key1_i && wr_stb_i) begin
			prepare_r <= cpu_do_i[0];
		end
	end

	// --------------------
	// joyp
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			p54_r <= 2'b00;
		else if (sel_joyp_i && wr_stb_i)
			p54_r <= cpu_do_i[5:4];
	end

	assign speed_o   = speed_r;
	assign joy_p54_o = p54_r;

	always_comb begin
		if (sel_key1_i)
			sys_do_o = {speed_r, 6'h3f, prepare_r};
		else if (sel_joyp_i)
			sys_do_o = {2'b11, p54_r, joy_din_i};   // buttons read live
		else
			sys_do_o = '1;
	end

endmodule

// File: gb_cart_bus.sv
// cartridge address, read/write strobes, chip select and open-bus decay
`timescale 1ns/10ps

module gb_cart_bus (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic [gb_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic [gb_pkg::DATA_W-1:0]  cpu_do_i,
	input  logic                       cpu_rd_n_i,
	input  logic                       wr_stb_i,
	input  logic                       sel_ext_i,
	input  logic [gb_pkg::DATA_W-1:0]  cart_do_i,
	input  logic                       cart_oe_i,
	output logic [14:0]                ext_addr_o,
	output logic                       ext_a15_o,
	output logic                       n_cs_o,
	output logic                       cart_rd_o,
	output logic                       cart_wr_o,
	output logic [gb_pkg::DATA_W-1:0]  cart_di_o,
	output logic [gb_pkg::DATA_W-1:0]  cart_rd_do_o
);

	logic [gb_pkg::DATA_W-1:0]  ob_data;   // last byte seen on the bus
	logic [2:0]                 ob_cnt;    // cycles without a driver
	logic                       sel_cram;

	assign sel_cram = (cpu_addr_i[15:13] == 3'b101);   // a000-bfff

	// --------------------
	// bus outputs
	// --------------------
	assign ext_addr_o = cpu_addr_i[14:0];
	assign ext_a15_o  = cpu_addr_i[15];
	assign n_cs_o     = ~(sel_ext_i & sel_cram);     // ram cs only
	assign cart_rd_o  = sel_ext_i & ~cpu_rd_n_i;
	assign cart_wr_o  = sel_ext_i & wr_stb_i;        // single cycle
	assign cart_di_o  = cpu_do_i;

	// --------------------
	// open bus
	// --------------------
	// bus capacitance holds the last byte, then pull-ups win
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ob_data <= '1;
			ob_cnt  <= gb_pkg::OPEN_BUS_DECAY;   // start fully decayed
		end else if (cart_oe_i) begin
			ob_data <= cart_do_i;
			ob_cnt  <= '0;
		end else if (ob_cnt != gb_pkg::OPEN_BUS_DECAY) begin
			ob_cnt <= ob_cnt + 3'd1;
			if (ob_cnt == gb_pkg::OPEN_BUS_DECAY - 3'd1)
				ob_data <= '1;   // slow pull-up reached
		end
	end

	assign cart_rd_do_o = cart_oe_i ? cart_do_i : ob_data;

endmodule

// File: gb_internal_ram.sv
// banked work ram with svbk bank register, and the zero-page ram
`timescale 1ns/10ps

module gb_internal_ram (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic                       is_gbc_i,
	input  logic [gb_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic [gb_pkg::DATA_W-1:0]  cpu_do_i,
	input  logic                       wr_stb_i,
	input  logic                       sel_wram_i,
	input  logic                       sel_hram_i,
	input  logic                       sel_svbk_i,
	output logic [gb_pkg::DATA_W-1:0]  ram_do_o,
	output logic [gb_pkg::DATA_W-1:0]  svbk_do_o
);

	logic [gb_pkg::DATA_W-1:0]       wram_mem [2**gb_pkg::WRAM_ADDR_W];
	logic [gb_pkg::DATA_W-1:0]       hram_mem [2**gb_pkg::HRAM_ADDR_W];
	logic [gb_pkg::DATA_W-1:0]       wram_q;
	logic [gb_pkg::DATA_W-1:0]       hram_q;
	logic                            hram_sel_q;   // which array the last read hit
	logic [gb_pkg::WRAM_BANK_W-1:0]  svbk_r;
	logic [gb_pkg::WRAM_BANK_W-1:0]  eff_bank;
	logic [gb_pkg::WRAM_OFS_W-1:0]   wram_ofs;
	logic [gb_pkg::WRAM_ADDR_W-1:0]  wram_addr;
	logic [gb_pkg::HRAM_ADDR_W-1:0]  hram_addr;

	// --------------------
	// bank mapping
	// --------------------
	// dmg has a fixed bank 1, svbk of 0 also selects bank 1
	assign eff_bank = !is_gbc_i ? 3'd1 : (svbk_r == '0) ? 3'd1 : svbk_r;
	assign wram_ofs = cpu_addr_i[gb_pkg::WRAM_OFS_W-1:0];
	// a12 picks the switchable half, echo area folds the same way
	assign wram_addr = cpu_addr_i[12] ? {eff_bank, wram_ofs}
		: {{gb_pkg::WRAM_BANK_W{1'b0}}, wram_ofs};
	assign hram_addr = cpu_addr_i[gb_pkg::HRAM_ADDR_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			svbk_r <= '0;
		else if (is_gbc_i && sel_svbk_i && wr_stb_i)
			svbk_r <= cpu_do_i[gb_pkg::WRAM_BANK_W-1:0];   // cgb only
	end

	assign svbk_do_o = sel_svbk_i ? {{(gb_pkg::DATA_W - gb_pkg::WRAM_BANK_W){1'b1}}, svbk_r}
		: '1;

	// --------------------
	// arrays
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (sel_wram_i && wr_stb_i)
			wram_mem[wram_addr] <= cpu_do_i;
		wram_q <= wram_mem[wram_addr];   // synchronous read
	end

	always_ff @(posedge clk_sys) begin
		if (sel_hram_i && wr_stb_i)
			hram_mem[hram_addr] <= cpu_do_i;
		hram_q <= hram_mem[hram_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			hram_sel_q <= 1'b0;
		else
			hram_sel_q <= sel_hram_i;
	end

	assign ram_do_o = hram_sel_q ? hram_q : wram_q;

endmodule

// File: gb_irq_ctrl.sv
// interrupt flag and enable registers, source edge capture, vectoring and ack clear
`timescale 1ns/10ps

module gb_irq_ctrl (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic                       sel_ie_i,
	input  logic                       sel_if_i,
	input  logic                       wr_stb_i,
	input  logic                       irq_ack_i,
	input  logic [gb_pkg::DATA_W-1:0]  cpu_do_i,
	input  logic                       vblank_irq_i,
	input  logic                       lcd_irq_i,
	input  logic                       timer_irq_i,
	input  logic                       serial_irq_i,
	input  logic [3:0]                 joy_din_i,
	output logic                       irq_n_o,
	output logic [gb_pkg::DATA_W-1:0]  irq_vec_o,
	output logic [gb_pkg::DATA_W-1:0]  if_do_o,
	output logic [gb_pkg::DATA_W-1:0]  ie_do_o
);

	logic [gb_pkg::IRQ_N-1:0]   if_r;        // flags
	logic [gb_pkg::DATA_W-1:0]  ie_r;        // enables, all 8 bits stored
	logic [3:0]                 src_q;       // previous source levels
	logic [3:0]                 joy_s1;      // joypad sync stage 1
	logic [3:0]                 joy_s2;      // joypad sync stage 2
	logic                       ack_q;       // ack level at last edge
	logic [gb_pkg::IRQ_N-1:0]   pend;        // flagged and enabled
	logic [gb_pkg::IRQ_N-1:0]   ack_mask;    // lowest pending, one-hot
	logic [gb_pkg::IRQ_N-1:0]   set_mask;
	logic [gb_pkg::IRQ_N-1:0]   clr_mask;
	logic [3:0]                 src;
	logic                       joy_fall;

	assign src      = {serial_irq_i, timer_irq_i, lcd_irq_i, vblank_irq_i};
	assign joy_fall = |(~joy_s1 & joy_s2);   // any line p10..p13 went low
	assign set_mask = {joy_fall, src & ~src_q};
	// end of the ack cycle drops the serviced flag
	assign clr_mask = (ack_q & ~irq_ack_i) ? ack_mask : '0;
	assign pend     = if_r & ie_r[gb_pkg::IRQ_N-1:0];

	// --------------------
	// priority and vector
	// --------------------
	always_comb begin
		irq_vec_o = '0;   // 00 when nothing pending
		ack_mask  = '0;
		// walk down so the lowest index is left standing
		for (int i = gb_pkg::IRQ_N - 1; i >= 0; i--) begin
			if (pend[i]) begin
				irq_vec_o   = gb_pkg::IRQ_VEC_BASE + gb_pkg::IRQ_VEC_STEP * 8'(i);
				ack_mask    = '0;
				ack_mask[i] = 1'b1;
			end
		end
	end

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r   <= '0;
			ie_r   <= '0;
			src_q  <= '0;
			joy_s1 <= '1;   // lines idle high
			joy_s2 <= '1;
			ack_q  <= 1'b0;
		end else begin
			src_q  <= src;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			ack_q  <= irq_ack_i;

			if_r <= (if_r | set_mask) & ~clr_mask;
			if (sel_if_i && wr_stb_i)
				if_r <= cpu_do_i[gb_pkg::IRQ_N-1:0];   // cpu write overrides events
			if (sel_ie_i && wr_stb_i)
				ie_r <= cpu_do_i;
		end
	end

	assign irq_n_o = ~|pend;   // low while anything enabled is flagged
	assign if_do_o = {{(gb_pkg::DATA_W - gb_pkg::IRQ_N){1'b1}}, if_r};
	assign ie_do_o = ie_r;

endmodule

// File: gb_bus_decode.sv
// cpu address decode, write falling-edge strobe and the cpu read-data mux
`timescale 1ns/10ps

module gb_bus_decode (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic [gb_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic                       cpu_wr_n_i,
	input  logic                       cpu_rd_n_i,
	input  logic                       cpu_m1_n_i,
	input  logic                       cpu_iorq_n_i,
	input  logic [gb_pkg::DATA_W-1:0]  irq_vec_i,
	input  logic [gb_pkg::DATA_W-1:0]  if_do_i,
	input  logic [gb_pkg::DATA_W-1:0]  ie_do_i,
	input  logic [gb_pkg::DATA_W-1:0]  ram_do_i,      // registered, one edge late
	input  logic [gb_pkg::DATA_W-1:0]  sys_do_i,      // svbk / key1 / joyp
	input  logic [gb_pkg::DATA_W-1:0]  cart_rd_do_i,
	output logic                       sel_ie_o,
	output logic                       sel_if_o,
	output logic                       sel_wram_o,
	output logic                       sel_hram_o,
	output logic                       sel_svbk_o,
	output logic                       sel_key1_o,
	output logic                       sel_joyp_o,
	output logic                       sel_ext_o,
	output logic                       wr_stb_o,
	output logic                       irq_ack_o,
	output logic [gb_pkg::DATA_W-1:0]  cpu_di_o
);

	logic wr_n_q;   // wr level at the previous edge

	// --------------------
	// memory map
	// --------------------
	assign sel_ie_o   = (cpu_addr_i == gb_pkg::ADDR_IE);
	assign sel_if_o   = (cpu_addr_i == gb_pkg::ADDR_IF);
	assign sel_svbk_o = (cpu_addr_i == gb_pkg::ADDR_SVBK);
	assign sel_key1_o = (cpu_addr_i == gb_pkg::ADDR_KEY1);
	assign sel_joyp_o = (cpu_addr_i == gb_pkg::ADDR_JOYP);
	// c000-fdff, echo area e000-fdff included
	assign sel_wram_o = (cpu_addr_i[15:14] == 2'b11) && ~&cpu_addr_i[13:9];
	// ff80-fffe, ffff belongs to ie
	assign sel_hram_o = &cpu_addr_i[15:7] && !sel_ie_o;
	// rom below 8000 or cart ram a000-bfff
	assign sel_ext_o  = ~cpu_addr_i[15] | (cpu_addr_i[15:13] == 3'b101);

	// interrupt acknowledge cycle
	assign irq_ack_o = ~cpu_iorq_n_i & ~cpu_m1_n_i;

	// --------------------
	// write strobe
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_n_q <= 1'b1;   // idle level
		end else begin
			wr_n_q <= cpu_wr_n_i;
		end
	end

	// only the high-to-low step counts, a held wr_n writes once
	assign wr_stb_o = wr_n_q & ~cpu_wr_n_i;

	// --------------------
	// read-data mux
	// --------------------
	always_comb begin
		if (irq_ack_o)
			cpu_di_o = irq_vec_i;          // vector wins during ack
		else if (cpu_rd_n_i)
			cpu_di_o = '1;                 // no read, bus floats high
		else if (sel_if_o)
			cpu_di_o = if_do_i;
		else if (sel_ie_o)
			cpu_di_o = ie_do_i;
		else if (sel_svbk_o | sel_key1_o | sel_joyp_o)
			cpu_di_o = sys_do_i;
		else if (sel_wram_o | sel_hram_o)
			cpu_di_o = ram_do_i;
		else if (sel_ext_o)
			cpu_di_o = cart_rd_do_i;       // cart or open bus
		else
			cpu_di_o = '1;                 // vram, oam, io holes
	end

endmodule

// File: gb_pkg.sv
// address map, bus widths, interrupt vectoring and open-bus decay constants
package gb_pkg;

	// --------------------
	// bus widths
	// --------------------
	localparam int ADDR_W = 16;        // cpu address
	localparam int DATA_W = 8;         // cpu / cart data

	// --------------------
	// interrupts
	// --------------------
	// sources 0..4 are vblank, lcd, timer, serial, joypad
	localparam int IRQ_N = 5;
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;    // vector of source 0
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;    // spacing between vectors

	// --------------------
	// internal ram geometry
	// --------------------
	localparam int WRAM_BANK_W = 3;    // svbk, banks 0..7
	localparam int WRAM_ADDR_W = 15;   // 8 x 4 KiB
	localparam int WRAM_OFS_W = 12;    // offset inside one bank
	localparam int HRAM_ADDR_W = 7;    // zero page, ff80..fffe

	// --------------------
	// register addresses
	// --------------------
	localparam logic [15:0] ADDR_IE = 16'hffff;     // interrupt enable
	localparam logic [15:0] ADDR_IF = 16'hff0f;     // interrupt flags
	localparam logic [15:0] ADDR_JOYP = 16'hff00;   // joypad line select
	localparam logic [15:0] ADDR_KEY1 = 16'hff4d;   // cgb speed switch
	localparam logic [15:0] ADDR_SVBK = 16'hff70;   // cgb wram bank

	// undriven cycles until the cart bus floats up to ff
	localparam logic [2:0] OPEN_BUS_DECAY = 3'd5;

endpackage
